// File: hw/kd_internal_node.sv
// Internal KD-tree node: stored split dimension and threshold,
// component compare and left/right valid steering
module kd_internal_node (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   wen,          // Node select from loader
  input  kd_tree_pkg::node_word_t wdata,
  input  logic                   valid_in,
  input  kd_tree_pkg::patch_t    patch_in,     // Shared level patch
  output logic                   valid_left,
  output logic                   valid_right
);

  import kd_tree_pkg::*;

  dim_t  dim_q;   // Split dimension
  comp_t thr_q;   // Split threshold
  comp_t comp;    // Selected patch component
  logic  go_left;

  // Split word storage
  // Cleared node is dim 0, thr 0, so it always routes right
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      dim_q <= '0;
      thr_q <= '0;
    end else if (wen) begin
      dim_q <= word_dim(wdata);
      thr_q <= word_thr(wdata);  // Reserved bits dropped
    end
  end

  assign comp = patch_comp(patch_in, dim_q);

  // Strictly less goes left, equal goes right
  // Out of range dimension always goes right
  always_comb begin
    if (dim_q >= DIM_LIMIT) go_left = 1'b0;
    else                    go_left = (comp < thr_q);
  end

  // Exactly one child gets the valid, none when idle
  assign valid_left  = valid_in &  go_left;
  assign valid_right = valid_in & ~go_left;

endmodule

// File: hw/kd_leaf_encoder.sv
// Leaf encoder: one-hot leaf valid vector to leaf index and valid flag
module kd_leaf_encoder #(
  parameter int DEPTH = 6
) (
  input  logic [(2**DEPTH)-1:0] leaf_onehot,
  output logic [DEPTH-1:0]      leaf_index,
  output logic                  leaf_valid
);

  localparam int NUM_LEAVES = 2**DEPTH;

  // Upward scan, so the highest set bit wins
  // Index stays 0 when no leaf is set
  always_comb begin
    leaf_index = '0;
    for (int i = 0; i < NUM_LEAVES; i++) begin
      if (leaf_onehot[i]) leaf_index = i[DEPTH-1:0];
    end
  end

  assign leaf_valid = |leaf_onehot;  // Any leaf reached

endmodule

// File: hw/kd_node_loader.sv
// Split word loader: breadth-first write address counter
// and one-hot node select decode
module kd_node_loader #(
  parameter int DEPTH = 6
) (
  input  logic                    clk,
  input  logic                    rst_n,
  input  logic                    fsm_enable,     // Loading phase
  input  logic                    sender_enable,  // Write strobe
  output logic [(2**DEPTH)-2:0]   node_sel        // One-hot, heap order
);

  localparam int NUM_NODES = (2**DEPTH) - 1;
  localparam logic [DEPTH-1:0] LAST_ADDR = DEPTH'(NUM_NODES - 1);

  logic             wen;
  logic [DEPTH-1:0] wadr;  // Heap address of the next node to write

  // Strobe only counts inside the loading phase
  assign wen = fsm_enable & sender_enable;

  // Address counter, wraps after the last internal node
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      wadr <= '0;
    end else if (wen) begin
      if (wadr == LAST_ADDR) wadr <= '0;
      else                   wadr <= wadr + 1'b1;
    end
  end

  // Decoder, all zero outside a write cycle
  always_comb begin
    for (int q = 0; q < NUM_NODES; q++) begin
      node_sel[q] = wen && (wadr == q[DEPTH-1:0]);
    end
  end

endmodule

// File: hw/kd_tree_level.sv
// One tree depth: 2^LEVEL internal nodes plus the patch and
// child valid registers feeding the next depth
module kd_tree_level #(
  parameter int LEVEL = 0
) (
  input  logic                      clk,
  input  logic                      rst_n,
  input  logic [(2**LEVEL)-1:0]     node_sel,   // Loader slice for this depth
  input  kd_tree_pkg::node_word_t   wdata,
  input  kd_tree_pkg::patch_t       patch_in,
  input  logic [(2**LEVEL)-1:0]     valid_in,   // One valid per node
  output kd_tree_pkg::patch_t       patch_out,
  output logic [(2**(LEVEL+1))-1:0] valid_out   // One valid per child
);

  localparam int NODES = 2**LEVEL;

  logic [2*NODES-1:0] child_valid;  // Unregistered child valids

  // Node j feeds children 2j (left) and 2j+1 (right)
  for (genvar j = 0; j < NODES; j++) begin : g_node
    kd_internal_node u_node (
      .clk        (clk),
      .rst_n      (rst_n),
      .wen        (node_sel[j]),
      .wdata      (wdata),           // Broadcast, select picks the node
      .valid_in   (valid_in[j]),
      .patch_in   (patch_in),
      .valid_left (child_valid[2*j]),
      .valid_right(child_valid[2*j+1])
    );
  end

  // Pipeline stage to the next depth
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      patch_out <= '0;
      valid_out <= '0;
    end else begin
      patch_out <= patch_in;     // Patch moves along with its valid bit
      valid_out <= child_valid;
    end
  end

endmodule

// File: hw/kd_tree_pkg.sv
// KD-tree search types: patch component, patch, dimension selector, node word
// Node word field layout and field/component access functions
package kd_tree_pkg;

  localparam int NUM_DIMS        = 5;
  localparam int COMP_WIDTH      = 11;
  localparam int PATCH_WIDTH     = NUM_DIMS * COMP_WIDTH;  // 55
  localparam int DIM_WIDTH       = 3;
  localparam int NODE_WORD_WIDTH = 22;
  localparam int DEFAULT_DEPTH   = 6;

  // Node word fields, bits 21..14 reserved
  localparam int THR_LSB = 0;
  localparam int DIM_LSB = COMP_WIDTH;

  typedef logic [COMP_WIDTH-1:0]      comp_t;       // Component or threshold, unsigned
  typedef logic [PATCH_WIDTH-1:0]     patch_t;      // Component 0 in the low bits
  typedef logic [DIM_WIDTH-1:0]       dim_t;
  typedef logic [NODE_WORD_WIDTH-1:0] node_word_t;

  // First dimension code past the patch, routes right
  localparam dim_t DIM_LIMIT = dim_t'(NUM_DIMS);

  function automatic comp_t word_thr(node_word_t w);
    return w[THR_LSB +: COMP_WIDTH];
  endfunction

  function automatic dim_t word_dim(node_word_t w);
    return w[DIM_LSB +: DIM_WIDTH];
  endfunction

  // Component pick, zero for a dimension beyond the patch
  function automatic comp_t patch_comp(patch_t p, dim_t d);
    comp_t c;
    c = '0;
    for (int i = 0; i < NUM_DIMS; i++) begin
      if (d == dim_t'(i)) c = p[i*COMP_WIDTH +: COMP_WIDTH];
    end
    return c;
  endfunction

endpackage

// File: hw/kd_tree_search.sv
// KD-tree search top: node loader, pipelined tree levels, leaf encoder
// Fixed latency of DEPTH cycles per query
module kd_tree_search #(
  parameter int DEPTH = kd_tree_pkg::DEFAULT_DEPTH
) (
  input  logic                    clk,
  input  logic                    rst_n,
  input  logic                    fsm_enable,
  input  logic                    sender_enable,
  input  kd_tree_pkg::node_word_t sender_data,
  input  logic                    query_valid,   // Root valid, travels with patch
  input  kd_tree_pkg::patch_t     patch_in,
  output logic [DEPTH-1:0]        leaf_index,
  output logic                    leaf_valid
);

  import kd_tree_pkg::*;

  // Valid bits in heap layout, depth k occupies [2^k-1 +: 2^k]
  // Depth DEPTH segment is the leaf vector
  localparam int VALID_BITS = (2**(DEPTH+1)) - 1;

  wire [(2**DEPTH)-2:0]   node_sel;
  wire [VALID_BITS-1:0]   valid_chain;
  wire patch_t            patch_chain [0:DEPTH];  // Patch entering each depth
  wire [(2**DEPTH)-1:0]   leaf_onehot;

  kd_node_loader #(.DEPTH(DEPTH)) u_loader (
    .clk          (clk),
    .rst_n        (rst_n),
    .fsm_enable   (fsm_enable),
    .sender_enable(sender_enable),
    .node_sel     (node_sel)
  );

  // Root takes the query without a register
  assign valid_chain[0] = query_valid;
  assign patch_chain[0] = patch_in;

  for (genvar k = 0; k < DEPTH; k++) begin : g_level
    kd_tree_level #(.LEVEL(k)) u_level (
      .clk      (clk),
      .rst_n    (rst_n),
      .node_sel (node_sel[(2**k)-1 +: 2**k]),   // Same heap slice as valids
      .wdata    (sender_data),
      .patch_in (patch_chain[k]),
      .valid_in (valid_chain[(2**k)-1 +: 2**k]),
      .patch_out(patch_chain[k+1]),
      .valid_out(valid_chain[(2**(k+1))-1 +: 2**(k+1)])
    );
  end

  assign leaf_onehot = valid_chain[(2**DEPTH)-1 +: 2**DEPTH];

  kd_leaf_encoder #(.DEPTH(DEPTH)) u_encoder (
    .leaf_onehot(leaf_onehot),
    .leaf_index (leaf_index),
    .leaf_valid (leaf_valid)
  );

endmodule

// File: kd_tree_search.f
hw/kd_tree_pkg.sv
hw/kd_node_loader.sv
hw/kd_internal_node.sv
hw/kd_tree_level.sv
hw/kd_leaf_encoder.sv
hw/kd_tree_search.sv
sim/kd_tree_search_chk.sv
sim/kd_tree_search_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build the KD-tree search testbench with Verilator, run it, check the log
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ps \
  --top-module kd_tree_search_tb \
  -f kd_tree_search.f \
  -o kd_tree_search_sim

# Keep running after an assertion error so the testbench prints its summary
./obj_dir/kd_tree_search_sim +verilator+error+limit+1000 > sim.log 2>&1 || true
cat sim.log

if grep -qx "Verification passed" sim.log; then
  exit 0
else
  echo "Simulation did not pass, see sim.log"
  exit 1
fi

// File: sim/kd_tree_search_chk.sv
// Bound assertions for the KD-tree search: one-hot leaf vector,
// reset state of leaf_valid and fixed query latency
module kd_tree_search_chk #(
  parameter int DEPTH = 6
) (
  input logic                  clk,
  input logic                  rst_n,
  input logic                  query_valid,
  input logic [(2**DEPTH)-1:0] leaf_onehot,  // Encoder input
  input logic                  leaf_valid
);

  timeunit 1ns;
  timeprecision 1ps;

  int unsigned assert_fails = 0;  // Summed into the testbench summary

  // A query reaches exactly one leaf
  a_leaf_onehot: assert property (@(posedge clk) disable iff (!rst_n) $onehot0(leaf_onehot))
    else begin
      assert_fails++;
      $error("leaf vector has more than one bit set: %b", leaf_onehot);
    end

  // Pipeline valids cleared by reset
  a_reset_idle: assert property (@(posedge clk) !rst_n |=> !leaf_valid)
    else begin
      assert_fails++;
      $error("leaf_valid high in the cycle after reset");
    end

  // One result per query, DEPTH cycles later, no extra pulses
  a_latency: assert property (@(posedge clk) disable iff (!rst_n)
                              leaf_valid == $past(query_valid, DEPTH))
    else begin
      assert_fails++;
      $error("leaf_valid does not follow query_valid by %0d cycles", DEPTH);
    end

endmodule

bind kd_tree_search kd_tree_search_chk #(.DEPTH(DEPTH)) u_chk (
  .clk        (clk),
  .rst_n      (rst_n),
  .query_valid(query_valid),
  .leaf_onehot(leaf_onehot),
  .leaf_valid (leaf_valid)
);

// File: sim/kd_tree_search_tb.sv
// KD-tree search testbench: tree loading, random and directed queries,
// reference walk of the tree, result compare and watchdog
module kd_tree_search_tb;

  timeunit 1ns;
  timeprecision 1ps;

  import kd_tree_pkg::*;

  localparam int DEPTH       = 6;
  localparam int NUM_NODES   = (2**DEPTH) - 1;
  localparam int PERIOD      = 4;
  localparam int N_WRITES    = 3 * NUM_NODES + (NUM_NODES + 10) + 20;  // Loads, wrap, stray pulses
  localparam int N_QUERIES   = 8 + 100 + 200 + 4 + 50 + 50;
  localparam int WATCHDOG_NS = (N_WRITES + N_QUERIES + DEPTH) * PERIOD * 2;

  logic             clk;
  logic             rst_n;
  logic             fsm_enable;
  logic             sender_enable;
  node_word_t       sender_data;
  logic             query_valid;
  patch_t           patch_in;
  logic [DEPTH-1:0] leaf_index;
  logic             leaf_valid;

  node_word_t       model_mem [NUM_NODES];  // Mirror of the node words, heap order
  int unsigned      model_wadr;             // Mirror of the loader counter
  logic [DEPTH-1:0] exp_q [$];              // Expected index per query in flight
  int unsigned      edge_q [$];             // Edge that launched each query
  int unsigned      edge_cnt;
  int unsigned      err_cnt;
  int unsigned      fail_cnt;
  int unsigned      total_fails;

  kd_tree_search #(.DEPTH(DEPTH)) u_dut (
    .clk          (clk),
    .rst_n        (rst_n),
    .fsm_enable   (fsm_enable),
    .sender_enable(sender_enable),
    .sender_data  (sender_data),
    .query_valid  (query_valid),
    .patch_in     (patch_in),
    .leaf_index   (leaf_index),
    .leaf_valid   (leaf_valid)
  );

  always #(PERIOD / 2) clk = ~clk;

  always @(posedge clk) edge_cnt <= edge_cnt + 1;

  // Walk from the root, left on component < threshold, right otherwise
  function automatic logic [DEPTH-1:0] ref_leaf(patch_t p);
    int unsigned      adr;
    int unsigned      dim;
    comp_t            thr;
    comp_t            comp;
    logic             right;
    logic [DEPTH-1:0] idx;
    adr = 0;
    idx = '0;
    for (int k = 0; k < DEPTH; k++) begin
      dim = model_mem[adr][13:11];
      thr = model_mem[adr][10:0];
      if (dim >= NUM_DIMS) right = 1'b1;  // Beyond the patch
      else begin
        comp  = p[dim*COMP_WIDTH +: COMP_WIDTH];
        right = !(comp < thr);
      end
      idx = {idx[DEPTH-2:0], right};      // MSB is the root decision
      adr = 2 * adr + 1 + right;
    end
    return idx;
  endfunction

  function automatic node_word_t make_word(int unsigned dim, int unsigned thr);
    node_word_t w;
    w        = node_word_t'($urandom);  // Reserved bits random, must be ignored
    w[13:11] = dim[2:0];
    w[10:0]  = thr[10:0];
    return w;
  endfunction

  function automatic patch_t rand_patch();
    patch_t p;
    for (int i = 0; i < NUM_DIMS; i++) p[i*COMP_WIDTH +: COMP_WIDTH] = comp_t'($urandom);
    return p;
  endfunction

  task automatic check_val(input string name, input logic [31:0] expected,
                           input logic [31:0] actual);
    if (expected !== actual) begin
      err_cnt++;
      $display("ERROR %0t ns %s expected %0d actual %0d", $time, name, expected, actual);
    end
  endtask

  task automatic write_word(input node_word_t w, input logic phase);
    @(posedge clk);
    fsm_enable    <= phase;  // Low phase makes the strobe a no-op
    sender_enable <= 1'b1;
    sender_data   <= w;
    query_valid   <= 1'b0;
  endtask

  task automatic send_query(input patch_t p);
    @(posedge clk);
    fsm_enable    <= 1'b0;
    sender_enable <= 1'b0;
    query_valid   <= 1'b1;
    patch_in      <= p;
  endtask

  task automatic idle();
    @(posedge clk);
    fsm_enable    <= 1'b0;
    sender_enable <= 1'b0;
    query_valid   <= 1'b0;
  endtask

  // Wait until every query in flight has come back
  task automatic drain();
    idle();
    while (exp_q.size() != 0) @(posedge clk);
  endtask

  // Compare results, then capture new queries and writes into the model
  always @(negedge clk) begin
    if (rst_n && leaf_valid) begin
      if (exp_q.size() == 0) begin
        fail_cnt++;
        $display("Unexpected leaf_valid at %0t ns with no query in flight", $time);
      end else begin
        check_val("leaf_index", exp_q.pop_front(), leaf_index);
        check_val("leaf_valid latency", DEPTH, edge_cnt - edge_q.pop_front());
      end
    end
    if (rst_n && query_valid) begin
      exp_q.push_back(ref_leaf(patch_in));
      edge_q.push_back(edge_cnt);
    end
    if (rst_n && fsm_enable && sender_enable) begin
      model_mem[model_wadr] = sender_data;
      model_wadr = (model_wadr == NUM_NODES - 1) ? 0 : model_wadr + 1;  // Same wrap as loader
    end
  end

  initial begin
    #(WATCHDOG_NS);
    $display("Timeout after %0d ns, results still outstanding: %0d", WATCHDOG_NS, exp_q.size());
    $display("Verification failed");
    $finish;
  end

  initial begin
    patch_t p;
    void'($urandom(38));
    clk = 1'b0;
    rst_n = 1'b0;
    fsm_enable = 1'b0;
    sender_enable = 1'b0;
    sender_data = '0;
    query_valid = 1'b0;
    patch_in = '0;
    edge_cnt = 0;
    err_cnt = 0;
    fail_cnt = 0;
    model_wadr = 0;
    for (int a = 0; a < NUM_NODES; a++) model_mem[a] = '0;  // Cleared nodes route right
    repeat (2) @(posedge clk);
    rst_n <= 1'b1;

    for (int i = 0; i < 8; i++) send_query(rand_patch());  // Unloaded tree, leaf 63
    drain();

    for (int a = 0; a < NUM_NODES; a++) write_word(make_word($urandom_range(NUM_DIMS - 1, 0),
                                                             $urandom), 1'b1);
    for (int i = 0; i < 100; i++) begin
      send_query(rand_patch());
      if ($urandom_range(3, 0) == 0) idle();               // Occasional gap
    end
    drain();

    for (int i = 0; i < 200; i++) send_query(rand_patch());  // One per cycle
    drain();

    // Every node sends a zero patch left, toward leaf 0
    for (int a = 0; a < NUM_NODES; a++) write_word(make_word(a % NUM_DIMS, 2047), 1'b1);
    send_query('0);
    drain();

    // Even depths use dims 5 to 7, odd depths tie on component 1
    // All-right path toward leaf 63 crosses both kinds
    for (int k = 0; k < DEPTH; k++) begin
      for (int j = 0; j < (1 << k); j++) begin
        if (k % 2 == 0) write_word(make_word(5 + k / 2, 2047), 1'b1);
        else            write_word(make_word(1, 700), 1'b1);
      end
    end
    p = '0;
    p[COMP_WIDTH +: COMP_WIDTH] = comp_t'(700);
    send_query(p);
    send_query('0);
    send_query(rand_patch());
    drain();

    // Ten writes past the last node land on nodes 0 to 9
    for (int a = 0; a < NUM_NODES + 10; a++) write_word(make_word($urandom_range(7, 0),
                                                                  $urandom), 1'b1);
    for (int i = 0; i < 50; i++) send_query(rand_patch());
    drain();

    for (int i = 0; i < 20; i++) write_word(make_word(0, 0), 1'b0);  // Outside loading phase
    for (int i = 0; i < 50; i++) send_query(rand_patch());
    idle();
    repeat (DEPTH + 2) @(posedge clk);

    if (exp_q.size() != 0) begin
      fail_cnt++;
      $display("%0d queries never produced a result", exp_q.size());
    end
    total_fails = err_cnt + fail_cnt + u_dut.u_chk.assert_fails;
    $display("Summary: %0d value errors, %0d other failures, %0d assertion failures",
             err_cnt, fail_cnt, u_dut.u_chk.assert_fails);
    if (total_fails == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

endmodule
